//--- logic/soc_pkg.sv
/* Peripheral bus types, address map and device table contents.
   Slots sit back to back from byte address 0 in index order. */
package soc_pkg;

	localparam int ARCH_BITSZ = 32;
	// Word address, bytes are reached through the selects
	localparam int ADDR_BITSZ = 30;

	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10,
		PI1_RW  = 2'b11
	} pi1_op_t;

	typedef struct packed {
		pi1_op_t                 op;
		logic [ADDR_BITSZ-1:0]   addr;
		logic [ARCH_BITSZ-1:0]   data;
		logic [ARCH_BITSZ/8-1:0] sel;
	} pi1_req_t;

	typedef struct packed {
		logic [ARCH_BITSZ-1:0] data;
		logic                  rdy;
	} pi1_rsp_t;

	localparam int S_DEVTBL    = 0;
	localparam int S_INTCTRL   = 1;
	localparam int S_BOOTRAM   = 2;
	localparam int S_INVALID   = 3;
	localparam int SLAVE_COUNT = 4;

	// Per-slot tables, element k belongs to slave index k
	localparam logic [SLAVE_COUNT-1:0][ARCH_BITSZ-1:0] SLAVE_MAPSZ =
		{32'h1000, 32'h100, 32'h100, 32'h100};
	localparam logic [SLAVE_COUNT-1:0][ARCH_BITSZ-1:0] SLAVE_ID =
		{32'd0, 32'd0, 32'd3, 32'd7};
	localparam logic [SLAVE_COUNT-1:0] SLAVE_USEINTR = 4'b0010;

	localparam int INT_SRC_COUNT = 2;
	localparam int INT_SRC_A     = 0;
	localparam int INT_SRC_B     = 1;

	typedef enum logic [1:0] {
		SWRST_NONE   = 2'b00,
		SWRST_PWROFF = 2'b01,
		SWRST_WARM   = 2'b10,
		SWRST_COLD   = 2'b11
	} swrst_t;

endpackage

//--- logic/reset_seq.sv
/* Bus reset stays high for 2^RST_CNTR_BITSZ-1 cycles after the last request.
   Power-off is sticky and only rst_p clears it. */
`timescale 1ns/1ps

module reset_seq #(
	parameter int RST_CNTR_BITSZ = 4
) (
	input  logic             clk24mhz,
	input  logic             rst_p,
	input  soc_pkg::swrst_t  swrst_i,
	output logic             sys_rst_o,
	output logic             pwroff_o
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      pwroff_q;
	logic                      restart;

	// Warm and cold codes both restart the sequence
	assign restart = rst_p
		|| (swrst_i == soc_pkg::SWRST_WARM)
		|| (swrst_i == soc_pkg::SWRST_COLD);

	always_ff @(posedge clk24mhz) begin
		if (restart)
			rst_cntr <= '1;
		else if (rst_cntr != '0)
			rst_cntr <= rst_cntr - 1'b1;
	end

	always_ff @(posedge clk24mhz) begin
		if (rst_p)
			pwroff_q <= 1'b0;
		else if (swrst_i == soc_pkg::SWRST_PWROFF)
			pwroff_q <= 1'b1;
	end

	assign sys_rst_o = (rst_cntr != '0) || pwroff_q;
	assign pwroff_o  = pwroff_q;

	// Once off, the bus stays in reset until the button
	a_pwroff_hold: assert property (@(posedge clk24mhz) disable iff (rst_p)
		pwroff_o |-> sys_rst_o ##1 (pwroff_o && sys_rst_o));

endmodule

//--- logic/pi1_decoder.sv
/* Single master address decoder, anything outside slots 0..2 goes to the
   default slave, which answers in the same cycle with zero data. */
`timescale 1ns/1ps

module pi1_decoder (
	input  logic                                clk24mhz,
	input  soc_pkg::pi1_req_t                   m_req_i,
	output soc_pkg::pi1_rsp_t                   m_rsp_o,
	output soc_pkg::pi1_req_t                   s_req_o,
	output logic [soc_pkg::SLAVE_COUNT-1:0]     s_sel_o,
	input  soc_pkg::pi1_rsp_t                   s_rsp_i [soc_pkg::SLAVE_COUNT-1]
);

	logic stray_rdy;

	// Request goes to every slave, only the selected one acts on it
	assign s_req_o = m_req_i;

	always_comb begin
		logic [soc_pkg::ARCH_BITSZ:0] byte_addr;
		logic [soc_pkg::ARCH_BITSZ:0] base;
		logic [soc_pkg::ARCH_BITSZ:0] limit;
		byte_addr = {1'b0, m_req_i.addr, 2'b00};
		base = '0;
		s_sel_o = '0;
		for (int k = 0; k < soc_pkg::S_INVALID; k++) begin
			limit = base + {1'b0, soc_pkg::SLAVE_MAPSZ[k]};
			if (byte_addr >= base && byte_addr < limit)
				s_sel_o[k] = 1'b1;
			base = limit;
		end
		// Unmapped address
		if (s_sel_o == '0)
			s_sel_o[soc_pkg::S_INVALID] = 1'b1;
	end

	always_comb begin
		m_rsp_o.data = '0;
		m_rsp_o.rdy  = 1'b0;
		if (s_sel_o[soc_pkg::S_INVALID]) begin
			m_rsp_o.rdy = (m_req_i.op != soc_pkg::PI1_NOP);
		end else begin
			for (int k = 0; k < soc_pkg::S_INVALID; k++) begin
				if (s_sel_o[k])
					m_rsp_o = s_rsp_i[k];
			end
		end
	end

	// A slave that is not addressed must not answer
	always_comb begin
		stray_rdy = 1'b0;
		for (int k = 0; k < soc_pkg::S_INVALID; k++) begin
			if (!s_sel_o[k] && s_rsp_i[k].rdy)
				stray_rdy = 1'b1;
		end
	end

	a_sel_onehot: assert property (@(posedge clk24mhz)
		(m_req_i.op != soc_pkg::PI1_NOP) |-> ($onehot(s_sel_o) && !stray_rdy));

endmodule

//--- logic/dev_table.sv
/* Read-only slot table plus the software reset word at word 2*SLAVE_COUNT.
   The stored reset code is cleared by sys_rst itself. */
`timescale 1ns/1ps

module dev_table (
	input  logic               clk24mhz,
	input  logic               sys_rst_i,
	input  soc_pkg::pi1_req_t  req_i,
	input  logic               sel_i,
	output soc_pkg::pi1_rsp_t  rsp_o,
	output soc_pkg::swrst_t    swrst_o
);

	localparam int WIDX_BITSZ = $clog2(soc_pkg::SLAVE_MAPSZ[soc_pkg::S_DEVTBL] / 4);
	localparam int SLOT_BITSZ = $clog2(soc_pkg::SLAVE_COUNT);
	localparam logic [WIDX_BITSZ-1:0] RST_WORD = WIDX_BITSZ'(2 * soc_pkg::SLAVE_COUNT);

	logic [WIDX_BITSZ-1:0]          widx;
	logic [SLOT_BITSZ-1:0]          slot;
	logic [soc_pkg::ARCH_BITSZ-1:0] rd_word;
	logic [soc_pkg::ARCH_BITSZ-1:0] rd_q;
	logic                           rdy_q;
	logic                           acc;
	logic                           wr;
	soc_pkg::swrst_t                swrst_q;

	assign widx = req_i.addr[WIDX_BITSZ-1:0];
	assign slot = widx[SLOT_BITSZ:1];
	assign acc  = !sys_rst_i && sel_i && (req_i.op != soc_pkg::PI1_NOP) && !rdy_q;
	assign wr   = (req_i.op == soc_pkg::PI1_WR) || (req_i.op == soc_pkg::PI1_RW);

	// Even words carry id and interrupt flag, odd words the map size
	always_comb begin
		rd_word = '0;
		if (widx < RST_WORD) begin
			if (!widx[0])
				rd_word = {soc_pkg::SLAVE_USEINTR[slot],
					soc_pkg::SLAVE_ID[slot][soc_pkg::ARCH_BITSZ-2:0]};
			else
				rd_word = soc_pkg::SLAVE_MAPSZ[slot];
		end else if (widx == RST_WORD) begin
			rd_word = {{(soc_pkg::ARCH_BITSZ-2){1'b0}}, swrst_q};
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			rdy_q   <= 1'b0;
			swrst_q <= soc_pkg::SWRST_NONE;
		end else begin
			rdy_q <= acc;
			if (acc && wr && widx == RST_WORD && req_i.sel[0])
				swrst_q <= soc_pkg::swrst_t'(req_i.data[1:0]);
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (acc)
			rd_q <= rd_word;
	end

	assign rsp_o.data = rd_q;
	assign rsp_o.rdy  = rdy_q;
	assign swrst_o    = swrst_q;

endmodule

//--- logic/int_ctrl.sv
/* One destination, fixed priority with the lowest source index winning.
   A source must drop its request within a cycle of its acknowledge pulse. */
`timescale 1ns/1ps

module int_ctrl (
	input  logic                              clk24mhz,
	input  logic                              sys_rst_i,
	input  soc_pkg::pi1_req_t                 req_i,
	input  logic                              sel_i,
	output soc_pkg::pi1_rsp_t                 rsp_o,
	input  logic [soc_pkg::INT_SRC_COUNT-1:0] int_src_i,
	output logic [soc_pkg::INT_SRC_COUNT-1:0] int_src_ack_o,
	output logic                              intrqst_o
);

	localparam int IDX_BITSZ  = $clog2(soc_pkg::INT_SRC_COUNT);
	localparam int WIDX_BITSZ = $clog2(soc_pkg::SLAVE_MAPSZ[soc_pkg::S_INTCTRL] / 4);

	logic [WIDX_BITSZ-1:0]             widx;
	logic                              acc;
	logic                              wr;
	logic                              rdy_q;
	logic [soc_pkg::ARCH_BITSZ-1:0]    rd_q;
	logic [soc_pkg::INT_SRC_COUNT-1:0] en_q;
	logic [soc_pkg::INT_SRC_COUNT-1:0] ack_q;
	logic                              pend_q;
	logic [IDX_BITSZ-1:0]              idx_q;
	logic                              hit;
	logic [IDX_BITSZ-1:0]              hit_idx;

	assign widx = req_i.addr[WIDX_BITSZ-1:0];
	assign acc  = !sys_rst_i && sel_i && (req_i.op != soc_pkg::PI1_NOP) && !rdy_q;
	assign wr   = (req_i.op == soc_pkg::PI1_WR) || (req_i.op == soc_pkg::PI1_RW);

	// Scan downwards so the lowest enabled request wins
	always_comb begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int k = soc_pkg::INT_SRC_COUNT - 1; k >= 0; k--) begin
			if (int_src_i[k] && en_q[k]) begin
				hit     = 1'b1;
				hit_idx = IDX_BITSZ'(k);
			end
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			rdy_q  <= 1'b0;
			en_q   <= '0;
			ack_q  <= '0;
			pend_q <= 1'b0;
			idx_q  <= '0;
		end else begin
			rdy_q <= acc;
			ack_q <= '0;
			if (acc && wr && widx == 1 && req_i.sel[0])
				en_q <= req_i.data[soc_pkg::INT_SRC_COUNT-1:0];
			if (acc && wr && widx == 0 && pend_q) begin
				ack_q[idx_q] <= 1'b1;
				pend_q       <= 1'b0;
			end else if (!pend_q && ack_q == '0 && hit) begin
				// Skip the ack cycle so the acked source can drop first
				pend_q <= 1'b1;
				idx_q  <= hit_idx;
			end
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (acc) begin
			if (widx == 0)
				rd_q <= {pend_q, {(soc_pkg::ARCH_BITSZ-1-IDX_BITSZ){1'b0}}, idx_q};
			else if (widx == 1)
				rd_q <= {{(soc_pkg::ARCH_BITSZ-soc_pkg::INT_SRC_COUNT){1'b0}}, en_q};
			else
				rd_q <= '0;
		end
	end

	assign rsp_o.data    = rd_q;
	assign rsp_o.rdy     = rdy_q;
	assign int_src_ack_o = ack_q;
	assign intrqst_o     = pend_q;

	// An ack only follows a pending request and ends it
	a_ack_onehot: assert property (@(posedge clk24mhz) disable iff (sys_rst_i)
		$onehot0(int_src_ack_o)
		and ((int_src_ack_o != '0) |-> (!intrqst_o && $past(intrqst_o))));

endmodule

//--- logic/boot_ram.sv
/* Word RAM with byte selects, contents survive reset.
   RW returns the old word and writes the selected new bytes. */
`timescale 1ns/1ps

module boot_ram #(
	parameter int RAM_WORDS = 64
) (
	input  logic               clk24mhz,
	input  logic               sys_rst_i,
	input  soc_pkg::pi1_req_t  req_i,
	input  logic               sel_i,
	output soc_pkg::pi1_rsp_t  rsp_o
);

	localparam int AW = $clog2(RAM_WORDS);

	logic [soc_pkg::ARCH_BITSZ-1:0] mem [RAM_WORDS];
	logic [soc_pkg::ARCH_BITSZ-1:0] rd_q;
	logic [AW-1:0]                  waddr;
	logic                           rdy_q;
	logic                           acc;
	logic                           wr;

	assign waddr = req_i.addr[AW-1:0];
	assign acc   = !sys_rst_i && sel_i && (req_i.op != soc_pkg::PI1_NOP) && !rdy_q;
	assign wr    = (req_i.op == soc_pkg::PI1_WR) || (req_i.op == soc_pkg::PI1_RW);

	always_ff @(posedge clk24mhz) begin
		if (acc) begin
			rd_q <= mem[waddr];
			for (int b = 0; b < soc_pkg::ARCH_BITSZ / 8; b++) begin
				if (wr && req_i.sel[b])
					mem[waddr][8*b +: 8] <= req_i.data[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i)
			rdy_q <= 1'b0;
		else
			rdy_q <= acc;
	end

	assign rsp_o.data = rd_q;
	assign rsp_o.rdy  = rdy_q;

endmodule

//--- logic/soc_top.sv
/* Peripheral bus with a single host port. Host ops are ignored until
   sys_rst_o falls. */
`timescale 1ns/1ps

module soc_top #(
	parameter int RST_CNTR_BITSZ = 4
) (
	input  logic                              clk24mhz,
	input  logic                              rst_p,
	input  soc_pkg::pi1_req_t                 host_req_i,
	output soc_pkg::pi1_rsp_t                 host_rsp_o,
	input  logic [soc_pkg::INT_SRC_COUNT-1:0] int_src_i,
	output logic [soc_pkg::INT_SRC_COUNT-1:0] int_src_ack_o,
	output logic                              intrqst_o,
	output logic                              sys_rst_o,
	output logic                              pwroff_o
);

	localparam int RAM_WORDS = soc_pkg::SLAVE_MAPSZ[soc_pkg::S_BOOTRAM] / 4;

	soc_pkg::pi1_req_t                   s_req;
	logic [soc_pkg::SLAVE_COUNT-1:0]     s_sel;
	soc_pkg::pi1_rsp_t                   s_rsp [soc_pkg::SLAVE_COUNT-1];
	soc_pkg::swrst_t                     swrst;
	logic                                sys_rst;

	reset_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) reset_seq0 (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.swrst_i   (swrst),
		.sys_rst_o (sys_rst),
		.pwroff_o  (pwroff_o)
	);

	pi1_decoder pi1_decoder0 (
		.clk24mhz (clk24mhz),
		.m_req_i  (host_req_i),
		.m_rsp_o  (host_rsp_o),
		.s_req_o  (s_req),
		.s_sel_o  (s_sel),
		.s_rsp_i  (s_rsp)
	);

	dev_table dev_table0 (
		.clk24mhz  (clk24mhz),
		.sys_rst_i (sys_rst),
		.req_i     (s_req),
		.sel_i     (s_sel[soc_pkg::S_DEVTBL]),
		.rsp_o     (s_rsp[soc_pkg::S_DEVTBL]),
		.swrst_o   (swrst)
	);

	int_ctrl int_ctrl0 (
		.clk24mhz      (clk24mhz),
		.sys_rst_i     (sys_rst),
		.req_i         (s_req),
		.sel_i         (s_sel[soc_pkg::S_INTCTRL]),
		.rsp_o         (s_rsp[soc_pkg::S_INTCTRL]),
		.int_src_i     (int_src_i),
		.int_src_ack_o (int_src_ack_o),
		.intrqst_o     (intrqst_o)
	);

	boot_ram #(
		.RAM_WORDS (RAM_WORDS)
	) boot_ram0 (
		.clk24mhz  (clk24mhz),
		.sys_rst_i (sys_rst),
		.req_i     (s_req),
		.sel_i     (s_sel[soc_pkg::S_BOOTRAM]),
		.rsp_o     (s_rsp[soc_pkg::S_BOOTRAM])
	);

	assign sys_rst_o = sys_rst;

endmodule

//--- sim/tb_soc.sv
/* Directed tests of the peripheral bus through the host port of soc_top.
   Source requests are dropped by the test right after their acknowledge. */
`timescale 1ns/1ps

module tb_soc;

	typedef logic [soc_pkg::ARCH_BITSZ-1:0]    word_t;
	typedef logic [soc_pkg::ADDR_BITSZ-1:0]    waddr_t;
	typedef logic [soc_pkg::ARCH_BITSZ/8-1:0]  sel_t;
	typedef logic [soc_pkg::INT_SRC_COUNT-1:0] src_t;

	localparam int CLK_PERIOD     = 40;
	localparam int BUS_TIMEOUT    = 8;
	localparam int RAM_TEST_WORDS = 8;
	// Watchdog budget in cycles, a transfer takes at most 4
	localparam int XFER_COUNT     = 60;
	localparam int RESET_CYCLES   = 24;
	localparam int WAIT_CYCLES    = 120;
	localparam int TEST_CYCLES    = XFER_COUNT * 4 + 2 * RESET_CYCLES + WAIT_CYCLES;
	localparam int MARGIN_CYCLES  = 100;

	logic              clk24mhz;
	logic              rst_p;
	soc_pkg::pi1_req_t host_req;
	soc_pkg::pi1_rsp_t host_rsp;
	src_t              int_src;
	src_t              int_src_ack;
	logic              intrqst;
	logic              sys_rst;
	logic              pwroff;

	int      errors;
	int      checks;
	logic [31:0] rng_state;
	word_t   ram_model [RAM_TEST_WORDS];
	src_t    ack_seen;
	logic    rqst_at_ack;

	soc_top #(
		.RST_CNTR_BITSZ (4)
	) dut0 (
		.clk24mhz      (clk24mhz),
		.rst_p         (rst_p),
		.host_req_i    (host_req),
		.host_rsp_o    (host_rsp),
		.int_src_i     (int_src),
		.int_src_ack_o (int_src_ack),
		.intrqst_o     (intrqst),
		.sys_rst_o     (sys_rst),
		.pwroff_o      (pwroff)
	);

	initial begin
		clk24mhz = 1'b0;
		forever #(CLK_PERIOD / 2) clk24mhz = ~clk24mhz;
	end

	// Record acknowledge pulses and the request line seen with them
	initial begin
		forever begin
			@(negedge clk24mhz);
			if (int_src_ack != '0) begin
				ack_seen    = ack_seen | int_src_ack;
				rqst_at_ack = intrqst;
			end
		end
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("%0d checks, %0d errors", checks, errors + 1);
		$display("Checks failed");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Slots are packed from address 0 in index order
	function automatic waddr_t slot_word(input int k);
		logic [31:0] bytes;
		bytes = '0;
		for (int j = 0; j < k; j++)
			bytes = bytes + soc_pkg::SLAVE_MAPSZ[j];
		return waddr_t'(bytes >> 2);
	endfunction

	function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
		input sel_t sel);
		word_t w;
		w = old_word;
		for (int b = 0; b < soc_pkg::ARCH_BITSZ / 8; b++) begin
			if (sel[b])
				w[8*b +: 8] = new_word[8*b +: 8];
		end
		return w;
	endfunction

	task automatic check_rsp_data(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_swrst(input string name, input soc_pkg::swrst_t got,
		input soc_pkg::swrst_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// One bus op: hold it until rdy, then return to NOP a cycle later
	task automatic transfer(input soc_pkg::pi1_op_t op, input waddr_t addr, input word_t wdata,
		input sel_t sel, output word_t rdata, output int latency);
		@(posedge clk24mhz);
		#5;
		host_req.op   = op;
		host_req.addr = addr;
		host_req.data = wdata;
		host_req.sel  = sel;
		latency = 0;
		@(negedge clk24mhz);
		while (host_rsp.rdy !== 1'b1 && latency < BUS_TIMEOUT) begin
			@(negedge clk24mhz);
			latency++;
		end
		rdata = host_rsp.data;
		if (host_rsp.rdy !== 1'b1) begin
			$display("No ready from the bus for op %h at word address %h", op, addr);
			errors++;
		end
		@(posedge clk24mhz);
		#5;
		host_req.op = soc_pkg::PI1_NOP;
	endtask

	task automatic bus_write(input waddr_t addr, input word_t wdata, input sel_t sel);
		word_t rdata;
		int    latency;
		transfer(soc_pkg::PI1_WR, addr, wdata, sel, rdata, latency);
	endtask

	task automatic bus_read(input waddr_t addr, output word_t rdata);
		int latency;
		transfer(soc_pkg::PI1_RD, addr, '0, '0, rdata, latency);
	endtask

	task automatic swap_word(input waddr_t addr, input word_t wdata, input sel_t sel,
		output word_t rdata);
		int latency;
		transfer(soc_pkg::PI1_RW, addr, wdata, sel, rdata, latency);
	endtask

	task automatic wait_intrqst(input int max_cycles);
		int n;
		n = 0;
		@(negedge clk24mhz);
		while (intrqst !== 1'b1 && n < max_cycles) begin
			@(negedge clk24mhz);
			n++;
		end
		if (intrqst !== 1'b1) begin
			$display("intrqst_o did not rise within %0d cycles", max_cycles);
			errors++;
		end
	endtask

	task automatic wait_sys_rst_low(input int max_cycles);
		int n;
		n = 0;
		@(negedge clk24mhz);
		while (sys_rst !== 1'b0 && n < max_cycles) begin
			@(negedge clk24mhz);
			n++;
		end
		if (sys_rst !== 1'b0) begin
			$display("sys_rst_o still high after %0d cycles", max_cycles);
			errors++;
		end
	endtask

	// Holds rst_p for 2 cycles and counts cycles until sys_rst_o falls
	task automatic reset_sequence();
		int cycles;
		rst_p = 1'b1;
		@(posedge clk24mhz);
		@(posedge clk24mhz);
		cycles = 2;
		#5;
		rst_p = 1'b0;
		@(negedge clk24mhz);
		check_bit("sys_rst_o", sys_rst, 1'b1);
		check_bit("pwroff_o", pwroff, 1'b0);
		check_bit("intrqst_o", intrqst, 1'b0);
		check_rsp_data("int_src_ack_o", word_t'(int_src_ack), '0);
		while (sys_rst === 1'b1 && cycles < RESET_CYCLES) begin
			@(posedge clk24mhz);
			cycles++;
			@(negedge clk24mhz);
		end
		checks++;
		if (sys_rst !== 1'b0 || cycles < 16 || cycles > 20) begin
			$display("sys_rst_o released after %0d cycles instead of 16 to 20", cycles);
			errors++;
		end
	endtask

	task automatic boot_ram_rw();
		word_t  rdata;
		word_t  wdata;
		sel_t   sel;
		waddr_t base;
		base = slot_word(soc_pkg::S_BOOTRAM);
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			ram_model[i] = next_random();
			bus_write(base + waddr_t'(i), ram_model[i], '1);
		end
		// Partial lanes, a different select pattern on each word
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			sel = sel_t'(i + 1);
			wdata = next_random();
			bus_write(base + waddr_t'(i), wdata, sel);
			ram_model[i] = merge_bytes(ram_model[i], wdata, sel);
		end
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			bus_read(base + waddr_t'(i), rdata);
			check_rsp_data($sformatf("host_rsp_o.data boot_ram[%0d]", i), rdata, ram_model[i]);
		end
		wdata = next_random();
		swap_word(base + waddr_t'(3), wdata, 4'b1100, rdata);
		check_rsp_data("host_rsp_o.data boot_ram[3] swap", rdata, ram_model[3]);
		ram_model[3] = merge_bytes(ram_model[3], wdata, 4'b1100);
		bus_read(base + waddr_t'(3), rdata);
		check_rsp_data("host_rsp_o.data boot_ram[3] after swap", rdata, ram_model[3]);
	endtask

	task automatic device_table();
		word_t  rdata;
		waddr_t base;
		base = slot_word(soc_pkg::S_DEVTBL);
		for (int k = 0; k < soc_pkg::SLAVE_COUNT; k++) begin
			bus_read(base + waddr_t'(2 * k), rdata);
			check_rsp_data($sformatf("host_rsp_o.data id of slot %0d", k), rdata,
				{soc_pkg::SLAVE_USEINTR[k], 31'b0} | soc_pkg::SLAVE_ID[k]);
			bus_read(base + waddr_t'(2 * k + 1), rdata);
			check_rsp_data($sformatf("host_rsp_o.data map size of slot %0d", k), rdata,
				soc_pkg::SLAVE_MAPSZ[k]);
		end
		bus_read(base + waddr_t'(2 * soc_pkg::SLAVE_COUNT), rdata);
		check_rsp_data("host_rsp_o.data reset word", rdata, '0);
		bus_read(base + waddr_t'(2 * soc_pkg::SLAVE_COUNT + 1), rdata);
		check_rsp_data("host_rsp_o.data unused word", rdata, '0);
	endtask

	task automatic invalid_address();
		word_t  rdata;
		int     latency;
		waddr_t inv;
		inv = slot_word(soc_pkg::S_INVALID);
		transfer(soc_pkg::PI1_RD, inv + waddr_t'(5), '0, '0, rdata, latency);
		check_rsp_data("host_rsp_o.data invalid slot", rdata, '0);
		check_bit("host_rsp_o.rdy in the op cycle", latency == 0, 1'b1);
		transfer(soc_pkg::PI1_RD, '1, '0, '0, rdata, latency);
		check_rsp_data("host_rsp_o.data top address", rdata, '0);
		// Low bits match boot RAM word 0, the interrupt mask and the reset word
		bus_write(inv, 32'hdead_beef, '1);
		bus_write(inv + waddr_t'(1), 32'h3, '1);
		bus_write(inv + waddr_t'(2 * soc_pkg::SLAVE_COUNT), 32'h2, '1);
		check_bit("sys_rst_o after invalid writes", sys_rst, 1'b0);
		bus_read(slot_word(soc_pkg::S_BOOTRAM), rdata);
		check_rsp_data("host_rsp_o.data boot_ram[0]", rdata, ram_model[0]);
		bus_read(slot_word(soc_pkg::S_INTCTRL) + waddr_t'(1), rdata);
		check_rsp_data("host_rsp_o.data interrupt mask", rdata, '0);
	endtask

	task automatic interrupt_priority();
		word_t  rdata;
		waddr_t base;
		logic   raised;
		base = slot_word(soc_pkg::S_INTCTRL);
		bus_write(base + waddr_t'(1), 32'h3, '1);
		bus_read(base + waddr_t'(1), rdata);
		check_rsp_data("host_rsp_o.data interrupt mask", rdata, 32'h3);
		int_src = 2'b11;
		wait_intrqst(4);
		bus_read(base, rdata);
		check_rsp_data("host_rsp_o.data pending source", rdata,
			32'h8000_0000 | soc_pkg::INT_SRC_A);
		ack_seen = '0;
		bus_write(base, '0, '1);
		check_rsp_data("int_src_ack_o pulses", word_t'(ack_seen), 32'h1);
		check_bit("intrqst_o during acknowledge", rqst_at_ack, 1'b0);
		int_src = int_src & ~ack_seen;
		wait_intrqst(4);
		bus_read(base, rdata);
		check_rsp_data("host_rsp_o.data pending source", rdata,
			32'h8000_0000 | soc_pkg::INT_SRC_B);
		ack_seen = '0;
		bus_write(base, '0, '1);
		check_rsp_data("int_src_ack_o pulses", word_t'(ack_seen), 32'h2);
		int_src = int_src & ~ack_seen;
		// Source B masked off must stay silent
		bus_write(base + waddr_t'(1), 32'h1, '1);
		int_src = 2'b10;
		raised = 1'b0;
		for (int n = 0; n < 8; n++) begin
			@(negedge clk24mhz);
			if (intrqst !== 1'b0)
				raised = 1'b1;
		end
		check_bit("intrqst_o with source B masked", raised, 1'b0);
		int_src = '0;
	endtask

	task automatic software_reset();
		word_t  rdata;
		waddr_t rst_word;
		waddr_t mask;
		logic   dropped;
		rst_word = slot_word(soc_pkg::S_DEVTBL) + waddr_t'(2 * soc_pkg::SLAVE_COUNT);
		mask = slot_word(soc_pkg::S_INTCTRL) + waddr_t'(1);
		bus_write(mask, 32'h3, '1);
		bus_write(rst_word, 32'h2, 4'h1);
		check_swrst("dev_table0.swrst_o", dut0.swrst, soc_pkg::SWRST_WARM);
		check_bit("sys_rst_o after warm code", sys_rst, 1'b1);
		wait_sys_rst_low(20);
		check_swrst("dev_table0.swrst_o", dut0.swrst, soc_pkg::SWRST_NONE);
		bus_read(mask, rdata);
		check_rsp_data("host_rsp_o.data interrupt mask", rdata, '0);
		bus_write(rst_word, 32'h3, 4'h1);
		check_swrst("dev_table0.swrst_o", dut0.swrst, soc_pkg::SWRST_COLD);
		check_bit("sys_rst_o after cold code", sys_rst, 1'b1);
		wait_sys_rst_low(20);
		bus_write(rst_word, 32'h1, 4'h1);
		check_bit("pwroff_o after power-off code", pwroff, 1'b1);
		dropped = 1'b0;
		for (int n = 0; n < RESET_CYCLES; n++) begin
			@(negedge clk24mhz);
			if (pwroff !== 1'b1 || sys_rst !== 1'b1)
				dropped = 1'b1;
		end
		check_bit("pwroff_o and sys_rst_o released before rst_p", dropped, 1'b0);
		@(posedge clk24mhz);
		#5;
		reset_sequence();
		// RAM keeps its words over any reset
		bus_read(slot_word(soc_pkg::S_BOOTRAM), rdata);
		check_rsp_data("host_rsp_o.data boot_ram[0] after reset", rdata, ram_model[0]);
	endtask

	initial begin
		rst_p     = 1'b1;
		host_req  = '0;
		int_src   = '0;
		errors    = 0;
		checks    = 0;
		rng_state = 32'he5dde3fa;
		ack_seen  = '0;
		rqst_at_ack = 1'b0;
		reset_sequence();
		boot_ram_rw();
		device_table();
		invalid_address();
		interrupt_priority();
		software_reset();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- list.f
logic/soc_pkg.sv
logic/reset_seq.sv
logic/pi1_decoder.sv
logic/dev_table.sv
logic/int_ctrl.sv
logic/boot_ram.sv
logic/soc_top.sv
sim/tb_soc.sv

//--- run.sh
#!/usr/bin/env bash
# Build tb_soc with Verilator, run it, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f list.f -o tb_soc \
	&& ./obj_dir/tb_soc > sim.log 2>&1 \
	|| echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
